/* Makefile */
# Verilator build and run of the mesh router testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f verilog.f --top-module tb_router \
		--Mdir $(OBJ_DIR) -o sim_router
	out=$$(./$(OBJ_DIR)/sim_router 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

/* logic/crossbar.sv */
`timescale 1ns/1ps
// Crossbar of the mesh router
// Masks each input valid onto the output its route selects
// Ties off loopback and, optionally, Y-to-X turns
// Returns the ready of the selected output to each input

module crossbar
  import noc_pkg::*;
#(
  parameter bit XY_ROUTE_OPT = 1'b1
) (
  input  logic        [NUM_PORTS-1:0]                in_valid_i,
  output logic        [NUM_PORTS-1:0]                in_ready_o,
  input  flit_t       [NUM_PORTS-1:0]                in_data_i,
  input  route_mask_t [NUM_PORTS-1:0]                in_route_i,
  // Indexed [output][input]
  output logic        [NUM_PORTS-1:0][NUM_PORTS-1:0] out_valid_o,
  input  logic        [NUM_PORTS-1:0][NUM_PORTS-1:0] out_ready_i,
  output flit_t       [NUM_PORTS-1:0][NUM_PORTS-1:0] out_data_o
);

  // Output readies seen from the input side, indexed [input][output]
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] ready_t;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
    for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
      // Loopback and Y-to-X paths are never used by XY routing
      if ((i == o) ||
          (XY_ROUTE_OPT && (i == NORTH || i == SOUTH) && (o == EAST || o == WEST)))
      begin : gen_tie
        assign out_valid_o[o][i] = 1'b0;
        assign out_data_o[o][i]  = '0;
        assign ready_t[i][o]     = 1'b0;
      end else begin : gen_conn
        assign out_valid_o[o][i] = in_valid_i[i] & in_route_i[i][o];
        assign out_data_o[o][i]  = in_data_i[i];
        assign ready_t[i][o]     = out_ready_i[o][i];
      end
    end

    // Unicast, so exactly one routed output answers
    assign in_ready_o[i] = |(ready_t[i] & in_route_i[i]);
  end

  // No flit heads back out of the port it entered
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      a_no_loopback: assert final (!(in_valid_i[i] && in_route_i[i][i]))
        else $error("crossbar: loopback route on input %0d", i);
    end
  end

  // Y traffic never turns back into X
  if (XY_ROUTE_OPT) begin : gen_xy_check
    always_comb begin
      a_no_y_to_x: assert final (
        !(in_valid_i[NORTH] && (in_route_i[NORTH][EAST] || in_route_i[NORTH][WEST])) &&
        !(in_valid_i[SOUTH] && (in_route_i[SOUTH][EAST] || in_route_i[SOUTH][WEST])))
        else $error("crossbar: Y-to-X turn requested");
    end
  end

endmodule

/* logic/input_port.sv */
`timescale 1ns/1ps
// Input port of the mesh router
// Registered circular FIFO for incoming flits
// Dimension-ordered XY route of the flit at the FIFO head
// Upstream handshake and FIFO occupancy assertions

module input_port
  import noc_pkg::*;
#(
  parameter int unsigned IN_FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  xy_id_t      xy_id_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  flit_t       data_i,
  output logic        valid_o,
  input  logic        ready_i,
  output flit_t       data_o,
  output route_mask_t route_o
);

  localparam int unsigned PTR_W = $clog2(IN_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(IN_FIFO_DEPTH + 1);

  // Flit storage
  flit_t mem_q [IN_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Full FIFO refuses new flits, no pass-through on a simultaneous pop
  assign ready_o = (count_q != CNT_W'(IN_FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(IN_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(IN_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // X first, then Y, then eject at the own coordinate
  always_comb begin
    route_o = '0;
    if (data_o.hdr.dst_id.x > xy_id_i.x) begin
      route_o[EAST] = 1'b1;
    end else if (data_o.hdr.dst_id.x < xy_id_i.x) begin
      route_o[WEST] = 1'b1;
    end else if (data_o.hdr.dst_id.y > xy_id_i.y) begin
      route_o[NORTH] = 1'b1;
    end else if (data_o.hdr.dst_id.y < xy_id_i.y) begin
      route_o[SOUTH] = 1'b1;
    end else begin
      route_o[EJECT] = 1'b1;
    end
  end

  // Sender keeps its offer up until the port accepts it
  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_o |=> valid_i)
    else $error("input_port: valid dropped while stalled");

  // Count stays in range and agrees with the pointers
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q <= CNT_W'(IN_FIFO_DEPTH)) &&
    ((wr_ptr_q == rd_ptr_q) == ((count_q == '0) || (count_q == CNT_W'(IN_FIFO_DEPTH)))))
    else $error("input_port: FIFO occupancy out of range");

endmodule

/* logic/noc_pkg.sv */
// Shared definitions for the mesh router
// Port count, coordinate and payload widths
// Port direction encoding used to index every per-port array
// Coordinate, flit header, flit and route mask types

package noc_pkg;

  // Eject plus the four mesh directions
  localparam int unsigned NUM_PORTS = 5;

  // Width of one mesh coordinate
  localparam int unsigned COORD_W = 3;

  // Width of the flit payload
  localparam int unsigned PAYLOAD_W = 32;

  // Port directions, Eject is the local port
  typedef enum logic [2:0] {
    EJECT = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } route_dir_e;

  // Mesh position of a router or endpoint
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } xy_id_t;

  // Header carried by every flit of a packet
  typedef struct packed {
    xy_id_t dst_id;
    xy_id_t src_id;
    // Marks the final flit of a packet
    logic   last;
  } flit_hdr_t;

  typedef struct packed {
    flit_hdr_t            hdr;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // One-hot output selection, one bit per port
  typedef logic [NUM_PORTS-1:0] route_mask_t;

endpackage

/* logic/noc_router.sv */
`timescale 1ns/1ps
// Five-port mesh router with XY routing
// Input FIFOs with route decision, crossbar, wormhole output arbiters

module noc_router
  import noc_pkg::*;
#(
  parameter int unsigned IN_FIFO_DEPTH = 4,
  parameter bit          XY_ROUTE_OPT  = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Own mesh position, static per instance
  input  xy_id_t                xy_id_i,
  input  logic  [NUM_PORTS-1:0] valid_i,
  output logic  [NUM_PORTS-1:0] ready_o,
  input  flit_t [NUM_PORTS-1:0] data_i,
  output logic  [NUM_PORTS-1:0] valid_o,
  input  logic  [NUM_PORTS-1:0] ready_i,
  output flit_t [NUM_PORTS-1:0] data_o
);

  // Input FIFO heads towards the crossbar
  logic        [NUM_PORTS-1:0] in_valid;
  logic        [NUM_PORTS-1:0] in_ready;
  flit_t       [NUM_PORTS-1:0] in_data;
  route_mask_t [NUM_PORTS-1:0] in_route;

  // Crossbar to arbiters, indexed [output][input]
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] xbar_valid;
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] xbar_ready;
  flit_t [NUM_PORTS-1:0][NUM_PORTS-1:0] xbar_data;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_input
    input_port #(
      .IN_FIFO_DEPTH ( IN_FIFO_DEPTH )
    ) i_input_port (
      .clk_i   ( clk_i       ),
      .rst_n_i ( rst_n_i     ),
      .xy_id_i ( xy_id_i     ),
      .valid_i ( valid_i[p]  ),
      .ready_o ( ready_o[p]  ),
      .data_i  ( data_i[p]   ),
      .valid_o ( in_valid[p] ),
      .ready_i ( in_ready[p] ),
      .data_o  ( in_data[p]  ),
      .route_o ( in_route[p] )
    );
  end

  crossbar #(
    .XY_ROUTE_OPT ( XY_ROUTE_OPT )
  ) i_crossbar (
    .in_valid_i  ( in_valid   ),
    .in_ready_o  ( in_ready   ),
    .in_data_i   ( in_data    ),
    .in_route_i  ( in_route   ),
    .out_valid_o ( xbar_valid ),
    .out_ready_i ( xbar_ready ),
    .out_data_o  ( xbar_data  )
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_output
    output_arbiter i_output_arbiter (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .valid_i ( xbar_valid[p] ),
      .ready_o ( xbar_ready[p] ),
      .data_i  ( xbar_data[p]  ),
      .valid_o ( valid_o[p]    ),
      .ready_i ( ready_i[p]    ),
      .data_o  ( data_o[p]     )
    );
  end

endmodule

/* logic/output_arbiter.sv */
`timescale 1ns/1ps
// Output arbiter of the mesh router
// Round-robin choice among the requesting inputs
// Wormhole lock held until the last flit of the packet leaves
// Output stability assertion under back-pressure

module output_arbiter
  import noc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic  [NUM_PORTS-1:0] valid_i,
  output logic  [NUM_PORTS-1:0] ready_o,
  input  flit_t [NUM_PORTS-1:0] data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output flit_t                 data_o
);

  localparam int unsigned IDX_W = $clog2(NUM_PORTS);

  // Previous winner, search starts just after it
  logic [IDX_W-1:0] rr_ptr_q;
  // Packet in progress and the input that owns the output
  logic             lock_q;
  logic [IDX_W-1:0] lock_idx_q;

  logic [IDX_W-1:0] rr_pick;
  logic             rr_found;
  logic [IDX_W-1:0] sel;
  logic             xfer_last;

  // First requester after the previous winner
  always_comb begin : rr_search
    int unsigned idx;
    rr_found = 1'b0;
    rr_pick  = rr_ptr_q;
    for (int unsigned k = 1; k <= NUM_PORTS; k++) begin
      idx = (rr_ptr_q + k) % NUM_PORTS;
      if (!rr_found && valid_i[idx]) begin
        rr_found = 1'b1;
        rr_pick  = IDX_W'(idx);
      end
    end
  end

  // Locked input keeps the output even through bubbles
  assign sel     = lock_q ? lock_idx_q : rr_pick;
  assign valid_o = lock_q ? valid_i[lock_idx_q] : rr_found;
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = ready_i;
  end

  assign xfer_last = valid_o & ready_i & data_o.hdr.last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // First grant after reset starts from Eject
      rr_ptr_q   <= IDX_W'(NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Lock once a flit is offered, so a stalled offer cannot switch inputs
      if (valid_o) begin
        lock_q     <= !xfer_last;
        lock_idx_q <= sel;
      end
      if (xfer_last) begin
        rr_ptr_q <= sel;
      end
    end
  end

  // Stalled output keeps the same flit on offer
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("output_arbiter: output changed while stalled");

endmodule

/* tests/tb_router.sv */
`timescale 1ns/1ps
// Directed testbench for the mesh router at coordinate (2,2)
// Clock, reset, LFSR payloads, flit driver and output monitor
// Tests for reset, XY routing, wormhole, round-robin and back-pressure

module tb_router
  import noc_pkg::*;
();

  localparam int     FIFO_DEPTH = 4;
  localparam int     TIMEOUT    = 200;
  localparam xy_id_t OWN_ID     = '{x: 3'd2, y: 3'd2};

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic  [NUM_PORTS-1:0] valid_i;
  logic  [NUM_PORTS-1:0] ready_o;
  flit_t [NUM_PORTS-1:0] data_i;
  logic  [NUM_PORTS-1:0] valid_o;
  logic  [NUM_PORTS-1:0] ready_i;
  flit_t [NUM_PORTS-1:0] data_o;

  // Galois LFSR state for payloads
  logic [15:0] lfsr_q = 16'd37;
  // Expected flits per output, and the last input served there
  flit_t exp_q [NUM_PORTS][$];
  int    last_in [NUM_PORTS];

  noc_router #(
    .IN_FIFO_DEPTH ( FIFO_DEPTH ),
    .XY_ROUTE_OPT  ( 1'b1       )
  ) DUT (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .xy_id_i ( OWN_ID  ),
    .valid_i ( valid_i ),
    .ready_o ( ready_o ),
    .data_i  ( data_i  ),
    .valid_o ( valid_o ),
    .ready_i ( ready_i ),
    .data_o  ( data_o  )
  );

  always #4 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Right shift with the taps folded in when the low bit is set
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return w;
  endfunction

  function automatic xy_id_t coord(input int x, input int y);
    xy_id_t c;
    c.x = COORD_W'(x);
    c.y = COORD_W'(y);
    return c;
  endfunction

  // Source of a flit names the neighbour behind its input port
  function automatic xy_id_t src_for(input int port);
    case (port)
      NORTH:   return coord(2, 3);
      EAST:    return coord(3, 2);
      SOUTH:   return coord(2, 1);
      WEST:    return coord(1, 2);
      default: return OWN_ID;
    endcase
  endfunction

  function automatic int port_of_src(input xy_id_t id);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (src_for(p) == id) begin
        return p;
      end
    end
    return 0;
  endfunction

  // X first, then Y, eject at own coordinate
  function automatic int route_of(input xy_id_t dst);
    if (dst.x > OWN_ID.x) return EAST;
    if (dst.x < OWN_ID.x) return WEST;
    if (dst.y > OWN_ID.y) return NORTH;
    if (dst.y < OWN_ID.y) return SOUTH;
    return EJECT;
  endfunction

  // First of two requesters after the last winner on that output
  function automatic int rr_winner(input int out, input int a, input int b);
    int idx;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (last_in[out] + k) % NUM_PORTS;
      if (idx == a || idx == b) begin
        return idx;
      end
    end
    return a;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  task automatic make_packet(input int src_port, input xy_id_t dst, input int len,
                             output flit_t pkt[$]);
    flit_t f;
    pkt = {};
    for (int k = 0; k < len; k++) begin
      f.hdr.dst_id = dst;
      f.hdr.src_id = src_for(src_port);
      f.hdr.last   = (k == len - 1);
      f.payload    = rand_word();
      pkt.push_back(f);
    end
  endtask

  task automatic expect_flit(input flit_t f);
    exp_q[route_of(f.hdr.dst_id)].push_back(f);
  endtask

  task automatic expect_packet(input flit_t pkt[$]);
    foreach (pkt[k]) begin
      expect_flit(pkt[k]);
    end
  endtask

  // Holds each flit on the input until the router takes it
  task automatic send_flits(input int port, input flit_t pkt[$]);
    int waited;
    @(posedge clk_i);
    #1;
    foreach (pkt[k]) begin
      valid_i[port] = 1'b1;
      data_i[port]  = pkt[k];
      waited = 0;
      @(negedge clk_i);
      while (!ready_o[port]) begin
        waited++;
        if (waited > TIMEOUT) fail_run($sformatf("Input %0d never became ready", port));
        else @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
    end
    valid_i[port] = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (pending() != 0) begin
      waited++;
      if (waited > TIMEOUT) fail_run("Expected flits never left the router");
      else @(negedge clk_i);
    end
  endtask

  // Every output transfer is compared with the oldest expected flit
  always @(negedge clk_i) begin
    flit_t exp_f;
    if (rst_n_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (valid_o[p] && ready_i[p]) begin
          if (exp_q[p].size() == 0) begin
            fail_run($sformatf("Unexpected flit on output %0d", p));
          end else begin
            exp_f = exp_q[p].pop_front();
            check($sformatf("data_o[%0d]", p), 64'(data_o[p]), 64'(exp_f));
            if (exp_f.hdr.last) last_in[p] = port_of_src(exp_f.hdr.src_id);
          end
        end
      end
    end
  end

  task automatic test_reset();
    @(negedge clk_i);
    check("valid_o", 64'(valid_o), 64'(0));
    check("ready_o", 64'(ready_o), 64'(5'h1f));
  endtask

  task automatic test_routing();
    flit_t  pkt[$];
    xy_id_t dst[5];
    dst = '{coord(4, 2), coord(0, 2), coord(2, 5), coord(2, 0), coord(3, 6)};
    foreach (dst[k]) begin
      make_packet(EJECT, dst[k], 1, pkt);
      expect_packet(pkt);
      send_flits(EJECT, pkt);
      drain();
    end
    // Traffic for this router leaves at Eject
    repeat (2) begin
      make_packet(WEST, OWN_ID, 1, pkt);
      expect_packet(pkt);
      send_flits(WEST, pkt);
      drain();
    end
  endtask

  task automatic test_wormhole();
    flit_t pw[$];
    flit_t ps[$];
    make_packet(WEST, coord(2, 6), 4, pw);
    make_packet(SOUTH, coord(2, 6), 4, ps);
    // Round-robin winner sends its whole packet first
    if (rr_winner(NORTH, WEST, SOUTH) == WEST) begin
      expect_packet(pw);
      expect_packet(ps);
    end else begin
      expect_packet(ps);
      expect_packet(pw);
    end
    fork
      send_flits(WEST, pw);
      send_flits(SOUTH, ps);
    join
    drain();
  endtask

  task automatic test_round_robin();
    flit_t qw[$];
    flit_t qe[$];
    flit_t one[$];
    int    first;
    for (int k = 0; k < 6; k++) begin
      make_packet(WEST, OWN_ID, 1, one);
      qw.push_back(one[0]);
      make_packet(EAST, OWN_ID, 1, one);
      qe.push_back(one[0]);
    end
    first = rr_winner(EJECT, WEST, EAST);
    // Grants alternate while both inputs keep requesting
    for (int k = 0; k < 6; k++) begin
      expect_flit(first == WEST ? qw[k] : qe[k]);
      expect_flit(first == WEST ? qe[k] : qw[k]);
    end
    fork
      send_flits(WEST, qw);
      send_flits(EAST, qe);
    join
    drain();
  endtask

  task automatic test_back_pressure();
    flit_t pkt[$];
    int    accepted;
    int    waited;
    make_packet(SOUTH, coord(2, 5), 6, pkt);
    expect_packet(pkt);
    @(posedge clk_i);
    #1;
    ready_i[NORTH] = 1'b0;
    fork
      send_flits(SOUTH, pkt);
      begin
        accepted = 0;
        waited   = 0;
        @(negedge clk_i);
        // Count accepted flits until the South FIFO is full
        while (ready_o[SOUTH]) begin
          if (valid_i[SOUTH]) accepted++;
          waited++;
          if (waited > TIMEOUT) fail_run("South input never stalled");
          else @(negedge clk_i);
        end
        check("accepted flits", 64'(accepted), 64'(FIFO_DEPTH));
        // Head flit stays on offer while stalled
        repeat (3) begin
          check("valid_o[NORTH]", 64'(valid_o[NORTH]), 64'(1));
          check("data_o[NORTH]", 64'(data_o[NORTH]), 64'(pkt[0]));
          @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        ready_i[NORTH] = 1'b1;
      end
    join
    drain();
  endtask

  initial begin
    rst_n_i = 1'b0;
    valid_i = '0;
    data_i  = '0;
    ready_i = '1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      last_in[p] = NUM_PORTS - 1;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_reset();
    test_routing();
    test_wormhole();
    test_round_robin();
    test_back_pressure();
    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog.f */
logic/noc_pkg.sv
logic/input_port.sv
logic/crossbar.sv
logic/output_arbiter.sv
logic/noc_router.sv
tests/tb_router.sv
